// ==== flist.f ====
rtl/pong_pkg.sv
rtl/tick_gen.sv
rtl/button_cond.sv
rtl/ping_pong_counter.sv
rtl/seg_scan.sv
rtl/seg_decode.sv
rtl/pong_display_top.sv
verif/tb_clk_gen.sv
verif/pong_checker.sv
verif/tb_pong.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pong -f flist.f -o tb_pong_sim
if [ $? -ne 0 ]; then
   echo "Verilator build did not complete"
   exit 1
fi

./obj_dir/tb_pong_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation binary returned status $run_status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "Log holds no final verdict"
   exit 1
fi
exit 0

// ==== verif/tb_pong.sv ====
`timescale 1ns/1ns

module tb_pong;

   localparam int cnt_div  = 64;
   localparam int ref_div  = 2;
   localparam int db_depth = 3;
   localparam int n_rows   = 15;

   typedef struct packed {
      logic [8*12-1:0] name;
      logic            en;
      logic [3:0]      max;
      logic [3:0]      min;
      logic            press;   // Flip pressed in the first interval
      logic            rnd;     // Bounds drawn at run time
      logic [7:0]      steps;
   } row_t;

   // name, enable, max, min, press, random, count intervals
   row_t rows [0:n_rows-1] = '{
      '{"reset",      1'b1, 4'd9,  4'd3,  1'b0, 1'b0, 8'd1},
      '{"pp_rise",    1'b1, 4'd9,  4'd3,  1'b0, 1'b0, 8'd5},
      '{"pp_fall",    1'b1, 4'd9,  4'd3,  1'b0, 1'b0, 8'd6},
      '{"pp_bounce",  1'b1, 4'd9,  4'd3,  1'b0, 1'b0, 8'd5},
      '{"two_digit",  1'b1, 4'd15, 4'd8,  1'b0, 1'b0, 8'd6},
      '{"top_bounce", 1'b1, 4'd15, 4'd8,  1'b0, 1'b0, 8'd3},
      '{"hold",       1'b0, 4'd15, 4'd8,  1'b0, 1'b0, 8'd4},
      '{"hold_flip",  1'b0, 4'd15, 4'd8,  1'b1, 1'b0, 8'd2},
      '{"flip_mid",   1'b1, 4'd15, 4'd8,  1'b1, 1'b0, 8'd2},
      '{"flip_back",  1'b1, 4'd15, 4'd8,  1'b1, 1'b0, 8'd2},
      '{"degenerate", 1'b1, 4'd13, 4'd13, 1'b0, 1'b0, 8'd3},
      '{"random_a",   1'b1, 4'd0,  4'd0,  1'b0, 1'b1, 8'd5},
      '{"random_b",   1'b1, 4'd0,  4'd0,  1'b0, 1'b1, 8'd5},
      '{"random_c",   1'b1, 4'd0,  4'd0,  1'b0, 1'b1, 8'd5},
      '{"random_d",   1'b1, 4'd0,  4'd0,  1'b0, 1'b1, 8'd5}
   };

   logic                       clk;
   logic                       rst_n;
   logic                       flip;
   logic                       enable;
   logic [pong_pkg::cnt_w-1:0] max;
   logic [pong_pkg::cnt_w-1:0] min;
   logic [pong_pkg::seg_w-1:0] seg;
   logic [pong_pkg::an_w-1:0]  an;
   logic                       check;
   logic [8*12-1:0]            cur_name;
   logic [pong_pkg::cnt_w-1:0] exp_cnt;
   logic                       exp_up;
   int                         pass_cnt;
   int                         fail_cnt;
   logic [pong_pkg::cnt_w-1:0] m_cnt;   // Reference model state
   logic                       m_up;

   tb_clk_gen #(.period(100), .rst_cycles(8)) u_clk_gen (.clk(clk), .rst_n(rst_n));

   pong_display_top #(.cnt_div(cnt_div), .ref_div(ref_div), .db_depth(db_depth)) u_dut (
      .clk(clk), .rst_n(rst_n), .flip(flip), .enable(enable),
      .max(max), .min(min), .seg(seg), .an(an)
   );

   pong_checker u_checker (
      .clk(clk), .seg(seg), .an(an), .check(check), .name(cur_name),
      .exp_cnt(exp_cnt), .exp_up(exp_up), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
   );

   // One count step: a pending flip first, then bounce and step if allowed
   task automatic model_step(input logic pressed);
      if (pressed) m_up = ~m_up;
      if (enable && max > min && m_cnt >= min && m_cnt <= max) begin
         if (m_cnt == min) begin
            m_up = 1'b1;
         end else if (m_cnt == max) begin
            m_up = 1'b0;
         end
         m_cnt = m_up ? m_cnt + 4'd1 : m_cnt - 4'd1;
      end
   endtask

   // Starts and ends 1 ns after a count step edge
   task automatic run_interval(input logic press, input logic do_check);
      flip = press;
      for (int c = 1; c <= cnt_div; c++) begin
         @(posedge clk);
         #1;
         if (c == 6 * ref_div) flip = 1'b0;
         if (do_check && c == cnt_div / 2) begin
            exp_cnt = m_cnt;
            exp_up  = m_up;
            check   = 1'b1;
         end else begin
            check = 1'b0;
         end
      end
      model_step(press);
   endtask

   initial begin
      row_t cur;
      flip     = 1'b0;
      enable   = 1'b1;
      max      = 4'd9;
      min      = 4'd3;
      check    = 1'b0;
      cur_name = '0;
      exp_cnt  = '0;
      exp_up   = 1'b0;
      m_cnt    = min;   // Counter loads min in reset
      m_up     = 1'b1;
      void'($urandom(32'hde8e));
      wait (rst_n === 1'b1);
      @(posedge clk);   // First count step comes cnt_div edges later
      #1;
      for (int r = 0; r < n_rows; r++) begin
         cur      = rows[r];
         cur_name = cur.name;
         enable   = cur.en;
         if (cur.rnd) begin
            min = 4'($urandom % 8);
            max = 4'(8 + $urandom % 8);
         end else begin
            min = cur.min;
            max = cur.max;
         end
         for (int s = 0; s < int'(cur.steps); s++) begin
            run_interval(cur.press && s == 0, s == int'(cur.steps) - 1);
         end
      end
      $display("Tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt == n_rows) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog sized from the total number of count intervals
   initial begin
      int total;
      total = 0;
      for (int r = 0; r < n_rows; r++) total += int'(rows[r].steps);
      #((total + 4) * cnt_div * 100);
      $display("Watchdog expired at %0t ns before all tests finished", $time);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== verif/pong_checker.sv ====
`timescale 1ns/1ns

module pong_checker (
   input  logic                       clk,
   input  logic [pong_pkg::seg_w-1:0] seg,
   input  logic [pong_pkg::an_w-1:0]  an,
   input  logic                       check,
   input  logic [8*12-1:0]            name,
   input  logic [pong_pkg::cnt_w-1:0] exp_cnt,
   input  logic                       exp_up,
   output int                         pass_cnt,
   output int                         fail_cnt
);

   logic [pong_pkg::seg_w-1:0] digit_seg [0:pong_pkg::an_w-1];   // Last full scan
   logic an_bad = 1'b0;   // Digit select seen with other than one digit active
   int passes = 0;
   int fails  = 0;

   assign pass_cnt = passes;
   assign fail_cnt = fails;

   // Numeral glyph back to its value or -1
   function automatic int glyph_value(input logic [pong_pkg::seg_w-1:0] g);
      for (int i = 0; i < 16; i++) begin
         if (g == pong_pkg::seg_digit[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   function automatic int glyph_dir(input logic [pong_pkg::seg_w-1:0] g);
      if (g == pong_pkg::seg_up) begin
         return 1;
      end else if (g == pong_pkg::seg_down) begin
         return 0;
      end
      return -1;
   endfunction

   function automatic string dir_name(input int d);
      return (d == 1) ? "up" : "down";
   endfunction

   task automatic compare_display();
      int tens;
      int ones;
      int dir_lo;
      int dir_hi;
      int got;
      tens   = glyph_value(digit_seg[pong_pkg::pos_tens]);
      ones   = glyph_value(digit_seg[pong_pkg::pos_ones]);
      dir_lo = glyph_dir(digit_seg[0]);
      dir_hi = glyph_dir(digit_seg[1]);
      got    = tens * 10 + ones;
      if (an_bad) begin
         $display("Test %0s at %0t ns: digit select did not keep exactly one digit active",
                  name, $time);
         fails++;
      end else if (tens < 0 || tens > 1 || ones < 0 || ones > 9) begin
         $display("Test %0s at %0t ns: count digits show glyphs %h and %h, no valid numerals",
                  name, $time, digit_seg[pong_pkg::pos_tens], digit_seg[pong_pkg::pos_ones]);
         fails++;
      end else if (dir_lo < 0 || dir_lo != dir_hi) begin
         $display("Test %0s at %0t ns: direction digits show glyphs %h and %h, no arrow",
                  name, $time, digit_seg[1], digit_seg[0]);
         fails++;
      end else if (got != int'(exp_cnt) || dir_lo != int'(exp_up)) begin
         $display("FAIL %0t ns %0s: expected count %0d %0s, observed count %0d %0s", $time,
                  name, exp_cnt, dir_name(int'(exp_up)), got, dir_name(dir_lo));
         fails++;
      end else begin
         $display("PASS %0t ns %0s: count %0d %0s", $time, name, got, dir_name(dir_lo));
         passes++;
      end
      an_bad = 1'b0;
   endtask

   // Capture each active digit while the display is stable
   always @(negedge clk) begin
      for (int i = 0; i < pong_pkg::an_w; i++) begin
         if (!an[i]) begin
            digit_seg[i] <= seg;
         end
      end
      if (!$isunknown(an) && $countones(an) != pong_pkg::an_w - 1) begin
         an_bad = 1'b1;
      end
      if (check) begin
         compare_display();
      end
   end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int period     = 100,
   parameter int rst_cycles = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // Release just after an edge, like every other input
   initial begin
      rst_n = 1'b0;
      repeat (rst_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

// ==== rtl/pong_display_top.sv ====
`timescale 1ns/1ns

module pong_display_top #(
   parameter int cnt_div  = 50_000_000,   // Half a second at 100 MHz
   parameter int ref_div  = 100_000,
   parameter int db_depth = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       flip,
   input  logic                       enable,
   input  logic [pong_pkg::cnt_w-1:0] max,
   input  logic [pong_pkg::cnt_w-1:0] min,
   output logic [pong_pkg::seg_w-1:0] seg,
   output logic [pong_pkg::an_w-1:0]  an
);

   logic                       count_tick;
   logic                       ref_tick;
   logic                       flip_pulse;
   logic [pong_pkg::cnt_w-1:0] cnt;
   logic                       up;
   logic [pong_pkg::cnt_w-1:0] value;
   logic                       is_num;

   tick_gen #(.div(cnt_div)) u_count_tick (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (count_tick)
   );

   tick_gen #(.div(ref_div)) u_ref_tick (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (ref_tick)
   );

   button_cond #(.db_depth(db_depth)) u_button_cond (
      .clk      (clk),
      .rst_n    (rst_n),
      .ref_tick (ref_tick),
      .button   (flip),
      .press    (flip_pulse)
   );

   ping_pong_counter u_counter (
      .clk        (clk),
      .rst_n      (rst_n),
      .count_tick (count_tick),
      .enable     (enable),
      .flip_pulse (flip_pulse),
      .max        (max),
      .min        (min),
      .cnt        (cnt),
      .up         (up)
   );

   seg_scan u_seg_scan (
      .clk      (clk),
      .rst_n    (rst_n),
      .ref_tick (ref_tick),
      .cnt      (cnt),
      .up       (up),
      .value    (value),
      .is_num   (is_num),
      .an       (an)
   );

   seg_decode u_seg_decode (
      .value  (value),
      .is_num (is_num),
      .up     (up),
      .seg    (seg)
   );

endmodule

// ==== rtl/seg_decode.sv ====
`timescale 1ns/1ns

module seg_decode (
   input  logic [pong_pkg::cnt_w-1:0] value,
   input  logic                       is_num,
   input  logic                       up,
   output logic [pong_pkg::seg_w-1:0] seg
);

   logic [pong_pkg::seg_w-1:0] glyph;

   // Arrow glyph for the direction digits
   assign glyph = up ? pong_pkg::seg_up : pong_pkg::seg_down;

   always_comb begin
      if (is_num) begin
         seg = pong_pkg::seg_digit[value];
      end else begin
         seg = glyph;
      end
   end

endmodule

// ==== rtl/seg_scan.sv ====
`timescale 1ns/1ns

module seg_scan (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       ref_tick,
   input  logic [pong_pkg::cnt_w-1:0] cnt,
   input  logic                       up,
   output logic [pong_pkg::cnt_w-1:0] value,
   output logic                       is_num,
   output logic [pong_pkg::an_w-1:0]  an
);

   logic [1:0] idx;
   logic       two_digit;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idx <= 2'd0;
      end else if (ref_tick) begin
         idx <= idx + 2'd1;   // Wraps after digit 3
      end
   end

   // One-cold digit select
   assign an = ~(pong_pkg::an_w'(1) << idx);

   assign two_digit = (cnt >= 4'd10);

   always_comb begin
      if (idx == pong_pkg::pos_tens) begin
         is_num = 1'b1;
         value  = two_digit ? 4'd1 : 4'd0;
      end else if (idx == pong_pkg::pos_ones) begin
         is_num = 1'b1;
         value  = two_digit ? cnt - 4'd10 : cnt;
      end else begin
         // Direction digits
         is_num = 1'b0;
         value  = {{(pong_pkg::cnt_w-1){1'b0}}, up};
      end
   end

endmodule

// ==== rtl/ping_pong_counter.sv ====
`timescale 1ns/1ns

module ping_pong_counter (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       count_tick,
   input  logic                       enable,
   input  logic                       flip_pulse,
   input  logic [pong_pkg::cnt_w-1:0] max,
   input  logic [pong_pkg::cnt_w-1:0] min,
   output logic [pong_pkg::cnt_w-1:0] cnt,
   output logic                       up
);

   logic pending;
   logic flip_req;
   logic up_flipped;
   logic can_step;
   logic step_up;

   // A press landing on the tick cycle itself still counts
   assign flip_req   = pending | flip_pulse;
   assign up_flipped = flip_req ? ~up : up;

   assign can_step = enable && (max > min) && (cnt >= min) && (cnt <= max);

   // Bounds override the requested direction
   always_comb begin
      if (cnt == min) begin
         step_up = 1'b1;
      end else if (cnt == max) begin
         step_up = 1'b0;
      end else begin
         step_up = up_flipped;
      end
   end

   // Holds a press until the next count step
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (count_tick) begin
         pending <= 1'b0;
      end else if (flip_pulse) begin
         pending <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= min;
         up  <= 1'b1;
      end else if (count_tick) begin
         if (can_step) begin
            up  <= step_up;
            cnt <= step_up ? cnt + 1'b1 : cnt - 1'b1;
         end else begin
            up <= up_flipped;   // Flip still applies while frozen
         end
      end
   end

endmodule

// ==== rtl/button_cond.sv ====
`timescale 1ns/1ns

module button_cond #(
   parameter int db_depth = 4
) (
   input  logic clk,
   input  logic rst_n,
   input  logic ref_tick,
   input  logic button,
   output logic press
);

   logic [db_depth-1:0] samples;
   logic                debounced;
   logic                debounced_d;

   // Sample the raw level only at the refresh rate
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         samples <= '0;
      end else if (ref_tick) begin
         samples <= {samples[db_depth-2:0], button};
      end
   end

   assign debounced = &samples;   // Stable high for db_depth samples

   // Rising edge of the clean level
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         debounced_d <= 1'b0;
         press       <= 1'b0;
      end else begin
         debounced_d <= debounced;
         press       <= debounced & ~debounced_d;
      end
   end

endmodule

// ==== rtl/tick_gen.sv ====
`timescale 1ns/1ns

module tick_gen #(
   parameter int div = 4
) (
   input  logic clk,
   input  logic rst_n,
   output logic tick
);

   localparam int cw = (div > 1) ? $clog2(div) : 1;

   logic [cw-1:0] cnt;

   // Down counter, strobe registered on the reload
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt  <= cw'(div - 1);
         tick <= 1'b0;
      end else if (cnt == '0) begin
         cnt  <= cw'(div - 1);
         tick <= 1'b1;
      end else begin
         cnt  <= cnt - 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

// ==== rtl/pong_pkg.sv ====
package pong_pkg;

   localparam int cnt_w = 4;
   localparam int seg_w = 8;   // Bits 0..6 are a..g, bit 7 is dp
   localparam int an_w  = 4;

   // Active low glyphs, upper and lower half of the digit
   localparam logic [seg_w-1:0] seg_up   = 8'b1101_1100;   // a, b, f
   localparam logic [seg_w-1:0] seg_down = 8'b1110_0011;   // c, d, e

   // Numerals 0..9, then hex letters with the dp lit
   localparam logic [seg_w-1:0] seg_digit [0:15] = '{
      8'b1100_0000, 8'b1111_1001, 8'b1010_0100, 8'b1011_0000,
      8'b1001_1001, 8'b1001_0010, 8'b1000_0010, 8'b1111_1000,
      8'b1000_0000, 8'b1001_0000, 8'b0000_1000, 8'b0000_0011,
      8'b0100_0110, 8'b0010_0001, 8'b0000_0110, 8'b0000_1110
   };

   localparam logic [1:0] pos_tens = 2'd3;
   localparam logic [1:0] pos_ones = 2'd2;   // Digits 1 and 0 carry the direction

endpackage
